//--- sources.f
src/ltssm_cfg_pkg.sv
src/link_timer.sv
src/os_transmitter.sv
src/config_fsm.sv
src/ltssm_config.sv
tb/tb_ltssm_config.sv

//--- src/config_fsm.sv
/* configuration substate sequencer */
`default_nettype none

module config_fsm #(
  parameter int NUM_LANES = 4
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire logic                 en_i,
  input  wire logic [NUM_LANES-1:0] link_width_satisfied_i,
  input  wire logic                 link_lanes_formed_i,
  input  wire logic                 link_lanes_nums_match_i,
  input  wire logic                 link_lane_reconfig_i,
  input  wire logic [NUM_LANES-1:0] config_complete_ts2_i,
  input  wire logic                 single_idle_rx_i,
  input  wire logic                 link_idle_satisfied_i,
  input  wire logic                 tx_busy_i,
  input  wire logic                 tx_done_i,
  input  wire logic                 timer_expired_i,
  output logic                      send_o,
  output ltssm_cfg_pkg::os_req_t    req_o,
  output logic                      timer_clear_o,
  output logic                      timer_run_o,
  output logic                      timer_long_o,
  output logic                      success_o,
  output logic                      error_o
);

  import ltssm_cfg_pkg::*;

  localparam int IDLE_CNT_W = $clog2(IDLE_RX_MIN + 1);

  typedef enum logic [3:0] {
    IDLE,
    LINK_WIDTH_START,
    LINK_WIDTH_TS1,
    WIDTH_ACCEPT,
    LANENUM_TS1,
    LANENUM_ACCEPT,
    COMPLETE_TS2,
    CONFIG_IDLE,
    WAIT_EN_LOW
  } state_e;

  state_e                state_r, next_state;
  logic                  success_r, success_c;
  logic                  error_r, error_c;
  logic [IDLE_CNT_W-1:0] idle_cnt_r, idle_cnt_c;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_r    <= IDLE;
      success_r  <= 1'b0;
      error_r    <= 1'b0;
      idle_cnt_r <= '0;
    end else begin
      state_r    <= next_state;
      success_r  <= success_c;
      error_r    <= error_c;
      idle_cnt_r <= idle_cnt_c;
    end
  end

  always_comb begin : fsm_comb
    next_state    = state_r;
    success_c     = success_r;
    error_c       = error_r;
    idle_cnt_c    = idle_cnt_r;
    send_o        = 1'b0;
    timer_clear_o = 1'b0;
    req_o         = '{kind: OS_TS1, lane_assigned: 1'b0, user: USER_FIRST_TS1};
    case (state_r)
      IDLE: begin
        idle_cnt_c = '0;
        if (en_i) begin
          timer_clear_o = 1'b1;
          next_state    = LINK_WIDTH_START;
        end
      end
      LINK_WIDTH_START: begin
        if (!tx_busy_i) begin
          send_o     = 1'b1;
          next_state = LINK_WIDTH_TS1;
        end
      end
      LINK_WIDTH_TS1: begin
        if (tx_done_i) begin
          if (|link_width_satisfied_i) begin
            timer_clear_o = 1'b1;
            next_state    = WIDTH_ACCEPT;
          end else if (timer_expired_i) begin
            error_c    = 1'b1;
            next_state = WAIT_EN_LOW;
          end
        end else if (!tx_busy_i) begin
          // resend PAD-lane TS1
          send_o = 1'b1;
        end
      end
      WIDTH_ACCEPT: begin
        if (link_lanes_formed_i && !tx_busy_i) begin
          send_o     = 1'b1;
          req_o      = '{kind: OS_TS1, lane_assigned: 1'b1, user: USER_LANE_OS};
          next_state = LANENUM_TS1;
        end else if (timer_expired_i) begin
          error_c    = 1'b1;
          next_state = WAIT_EN_LOW;
        end
      end
      LANENUM_TS1: begin
        if (tx_done_i) begin
          next_state = LANENUM_ACCEPT;
        end
      end
      LANENUM_ACCEPT: begin
        if (!tx_busy_i) begin
          if (link_lanes_nums_match_i) begin
            timer_clear_o = 1'b1;
            send_o        = 1'b1;
            req_o         = '{kind: OS_TS2, lane_assigned: 1'b1, user: USER_LANE_OS};
            next_state    = COMPLETE_TS2;
          end else if (link_lane_reconfig_i) begin
            send_o     = 1'b1;
            req_o      = '{kind: OS_TS1, lane_assigned: 1'b1, user: USER_LANE_OS};
            next_state = LANENUM_TS1;
          end
        end
      end
      COMPLETE_TS2: begin
        req_o = '{kind: OS_TS2, lane_assigned: 1'b1, user: USER_LANE_OS};
        if (tx_done_i) begin
          if (&config_complete_ts2_i) begin
            idle_cnt_c = '0;
            next_state = CONFIG_IDLE;
          end else if (timer_expired_i) begin
            error_c    = 1'b1;
            next_state = WAIT_EN_LOW;
          end
        end else if (!tx_busy_i) begin
          send_o = 1'b1;
        end
      end
      CONFIG_IDLE: begin
        req_o = '{kind: OS_IDLE, lane_assigned: 1'b1, user: USER_LANE_OS};
        if (tx_done_i) begin
          // count saturates at the minimum
          if (single_idle_rx_i && (idle_cnt_r < IDLE_CNT_W'(IDLE_RX_MIN))) begin
            idle_cnt_c = idle_cnt_r + 1'b1;
          end
          if (link_idle_satisfied_i && (idle_cnt_r >= IDLE_CNT_W'(IDLE_RX_MIN))) begin
            success_c  = 1'b1;
            next_state = WAIT_EN_LOW;
          end
        end else if (!tx_busy_i) begin
          send_o = 1'b1;
        end
      end
      WAIT_EN_LOW: begin
        if (!en_i) begin
          success_c  = 1'b0;
          error_c    = 1'b0;
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  // 24 ms window while negotiating width, 2 ms afterwards
  assign timer_long_o = state_r inside {IDLE, LINK_WIDTH_START, LINK_WIDTH_TS1};
  assign timer_run_o  = state_r inside {LINK_WIDTH_START, LINK_WIDTH_TS1, WIDTH_ACCEPT,
                                        COMPLETE_TS2};

  assign success_o = success_r;
  assign error_o   = error_r;

  a_result_onehot: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(success_o && error_o)
  );

  // transmitter is idle on a send and picks it up next cycle
  a_send_taken: assert property (
    @(posedge clk_i) disable iff (rst_i)
    send_o |-> !tx_busy_i ##1 tx_busy_i
  );

endmodule

`default_nettype wire

//--- src/link_timer.sv
/* link timeout counter */
`default_nettype none

module link_timer #(
  // 24 ms and 2 ms at a 250 MHz clock
  parameter ltssm_cfg_pkg::timer_t LONG_TIMEOUT  = 32'd6_000_000,
  parameter ltssm_cfg_pkg::timer_t SHORT_TIMEOUT = 32'd500_000
) (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic clear_i,
  input  wire logic run_i,
  input  wire logic long_sel_i,
  output logic      expired_o
);

  import ltssm_cfg_pkg::*;

  timer_t count_r;
  timer_t limit;

  assign limit = long_sel_i ? LONG_TIMEOUT : SHORT_TIMEOUT;

  // saturates at the selected limit
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_r <= '0;
    end else if (clear_i) begin
      count_r <= '0;
    end else if (run_i && (count_r < limit)) begin
      count_r <= count_r + 1'b1;
    end
  end

  assign expired_o = (count_r >= limit);

endmodule

`default_nettype wire

//--- src/ltssm_cfg_pkg.sv
/* ltssm configuration shared types */
`default_nettype none

package ltssm_cfg_pkg;

  // plain widths
  typedef logic [7:0]  symbol_t;
  typedef logic [31:0] beat_t;
  typedef logic [7:0]  stream_user_t;
  typedef logic [31:0] timer_t;

  typedef enum logic [1:0] {
    OS_TS1,
    OS_TS2,
    OS_IDLE
  } os_kind_e;

  // one ordered-set request from the state machine
  typedef struct packed {
    os_kind_e     kind;
    // lane number 0 when set, PAD otherwise
    logic         lane_assigned;
    stream_user_t user;
  } os_req_t;

  // 8b/10b symbol codes
  localparam symbol_t SYM_COM    = 8'hBC;
  localparam symbol_t SYM_PAD    = 8'hF7;
  localparam symbol_t SYM_TS1_ID = 8'h4A;
  localparam symbol_t SYM_TS2_ID = 8'h45;
  localparam symbol_t SYM_IDLE   = 8'h00;

  // training set fields
  localparam symbol_t NFTS_VALUE = 8'h10;
  localparam symbol_t RATE_GEN1  = 8'h02;

  // sideband tags
  localparam stream_user_t USER_FIRST_TS1 = 8'h01;
  localparam stream_user_t USER_LANE_OS   = 8'h03;

  // 16 symbols in 32-bit beats
  localparam int BEATS_PER_OS = 4;

  // idles received before the link is declared up
  localparam int IDLE_RX_MIN = 16;

endpackage

`default_nettype wire

//--- src/ltssm_config.sv
/* ltssm configuration stage */
`default_nettype none

module ltssm_config #(
  parameter int                    NUM_LANES     = 4,
  parameter int                    LINK_NUM      = 0,
  parameter ltssm_cfg_pkg::timer_t LONG_TIMEOUT  = 32'd6_000_000,
  parameter ltssm_cfg_pkg::timer_t SHORT_TIMEOUT = 32'd500_000
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   en_i,
  input  wire logic [NUM_LANES-1:0]   link_width_satisfied_i,
  input  wire logic                   link_lanes_formed_i,
  input  wire logic                   link_lanes_nums_match_i,
  input  wire logic                   link_lane_reconfig_i,
  input  wire logic [NUM_LANES-1:0]   config_complete_ts2_i,
  input  wire logic                   single_idle_rx_i,
  input  wire logic                   link_idle_satisfied_i,
  output ltssm_cfg_pkg::beat_t        os_tdata_o,
  output ltssm_cfg_pkg::stream_user_t os_tuser_o,
  output logic                        os_tvalid_o,
  output logic                        os_tlast_o,
  input  wire logic                   os_tready_i,
  output logic                        success_o,
  output logic                        error_o
);

  import ltssm_cfg_pkg::*;

  os_req_t tx_req;
  logic    tx_send;
  logic    tx_busy;
  logic    tx_done;
  logic    timer_clear;
  logic    timer_run;
  logic    timer_long;
  logic    timer_expired;

  config_fsm #(
    .NUM_LANES (NUM_LANES)
  ) u_config_fsm (
    .clk_i                   (clk_i),
    .rst_i                   (rst_i),
    .en_i                    (en_i),
    .link_width_satisfied_i  (link_width_satisfied_i),
    .link_lanes_formed_i     (link_lanes_formed_i),
    .link_lanes_nums_match_i (link_lanes_nums_match_i),
    .link_lane_reconfig_i    (link_lane_reconfig_i),
    .config_complete_ts2_i   (config_complete_ts2_i),
    .single_idle_rx_i        (single_idle_rx_i),
    .link_idle_satisfied_i   (link_idle_satisfied_i),
    .tx_busy_i               (tx_busy),
    .tx_done_i               (tx_done),
    .timer_expired_i         (timer_expired),
    .send_o                  (tx_send),
    .req_o                   (tx_req),
    .timer_clear_o           (timer_clear),
    .timer_run_o             (timer_run),
    .timer_long_o            (timer_long),
    .success_o               (success_o),
    .error_o                 (error_o)
  );

  link_timer #(
    .LONG_TIMEOUT  (LONG_TIMEOUT),
    .SHORT_TIMEOUT (SHORT_TIMEOUT)
  ) u_link_timer (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .clear_i    (timer_clear),
    .run_i      (timer_run),
    .long_sel_i (timer_long),
    .expired_o  (timer_expired)
  );

  os_transmitter #(
    .LINK_NUM (LINK_NUM)
  ) u_os_transmitter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .send_i      (tx_send),
    .req_i       (tx_req),
    .os_tready_i (os_tready_i),
    .busy_o      (tx_busy),
    .done_o      (tx_done),
    .os_tdata_o  (os_tdata_o),
    .os_tuser_o  (os_tuser_o),
    .os_tvalid_o (os_tvalid_o),
    .os_tlast_o  (os_tlast_o)
  );

endmodule

`default_nettype wire

//--- src/os_transmitter.sv
/* ordered-set transmitter */
`default_nettype none

module os_transmitter #(
  parameter int LINK_NUM = 0
) (
  input  wire logic                          clk_i,
  input  wire logic                          rst_i,
  input  wire logic                          send_i,
  input  wire ltssm_cfg_pkg::os_req_t        req_i,
  input  wire logic                          os_tready_i,
  output logic                               busy_o,
  output logic                               done_o,
  output ltssm_cfg_pkg::beat_t               os_tdata_o,
  output ltssm_cfg_pkg::stream_user_t        os_tuser_o,
  output logic                               os_tvalid_o,
  output logic                               os_tlast_o
);

  import ltssm_cfg_pkg::*;

  localparam int BEAT_W      = $bits(beat_t);
  localparam int SYMS_PER_OS = BEATS_PER_OS * BEAT_W / $bits(symbol_t);
  localparam int OS_BITS     = BEATS_PER_OS * BEAT_W;
  localparam int BEAT_CNT_W  = $clog2(BEATS_PER_OS);

  // symbol 0 lands in the low byte of beat 0
  function automatic logic [OS_BITS-1:0] build_os(input os_req_t req);
    symbol_t [SYMS_PER_OS-1:0] sym;
    symbol_t                   ts_id;
    ts_id = (req.kind == OS_TS2) ? SYM_TS2_ID : SYM_TS1_ID;
    if (req.kind == OS_IDLE) begin
      sym = {SYMS_PER_OS{SYM_IDLE}};
    end else begin
      sym[0] = SYM_COM;
      sym[1] = symbol_t'(LINK_NUM);
      sym[2] = req.lane_assigned ? 8'h00 : SYM_PAD;
      sym[3] = NFTS_VALUE;
      sym[4] = RATE_GEN1;
      sym[5] = 8'h00;
      for (int i = 6; i < SYMS_PER_OS; i++) begin
        sym[i] = ts_id;
      end
    end
    return sym;
  endfunction

  logic [OS_BITS-1:0]    os_new;
  logic [OS_BITS-1:0]    os_r;
  logic [BEAT_CNT_W-1:0] beat_cnt_r;
  logic [BEAT_CNT_W-1:0] next_cnt;
  logic                  tvalid_r;
  logic                  tlast_r;
  beat_t                 tdata_r;
  stream_user_t          tuser_r;
  logic                  beat_xfer;

  assign os_new    = build_os(req_i);
  assign next_cnt  = beat_cnt_r + 1'b1;
  assign beat_xfer = tvalid_r && os_tready_i;

  // handshake control
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      tvalid_r   <= 1'b0;
      tlast_r    <= 1'b0;
      beat_cnt_r <= '0;
    end else if (send_i) begin
      tvalid_r   <= 1'b1;
      tlast_r    <= (BEATS_PER_OS == 1);
      beat_cnt_r <= '0;
    end else if (beat_xfer) begin
      if (tlast_r) begin
        tvalid_r <= 1'b0;
        tlast_r  <= 1'b0;
      end else begin
        beat_cnt_r <= next_cnt;
        tlast_r    <= (beat_cnt_r == BEAT_CNT_W'(BEATS_PER_OS - 2));
      end
    end
  end

  // payload, held while ready is low
  always_ff @(posedge clk_i) begin
    if (send_i) begin
      os_r    <= os_new;
      tdata_r <= os_new[BEAT_W-1:0];
      tuser_r <= req_i.user;
    end else if (beat_xfer && !tlast_r) begin
      tdata_r <= os_r[next_cnt*BEAT_W +: BEAT_W];
    end
  end

  assign os_tdata_o  = tdata_r;
  assign os_tuser_o  = tuser_r;
  assign os_tvalid_o = tvalid_r;
  assign os_tlast_o  = tlast_r;
  assign busy_o      = tvalid_r;
  assign done_o      = beat_xfer && tlast_r;

  // a stalled beat stays put until it is taken
  a_stall_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (os_tvalid_o && !os_tready_i) |=>
      (os_tvalid_o && $stable(os_tdata_o) && $stable(os_tuser_o) && $stable(os_tlast_o))
  );

endmodule

`default_nettype wire

//--- tb/tb_ltssm_config.sv
/* ltssm configuration testbench */
`default_nettype none

module tb_ltssm_config;

  import ltssm_cfg_pkg::*;

  localparam int NUM_LANES = 4;
  localparam int LINK_NUM  = 0;
  localparam int LONG_TO   = 400;
  localparam int SHORT_TO  = 200;
  // loose bound on one ordered set under random ready
  localparam int OS_CYCLES       = 24;
  localparam int TRAIN_CYCLES    = 32 * OS_CYCLES;
  localparam int WIDTH_CYCLES    = LONG_TO + 4 * OS_CYCLES;
  localparam int TS2_CYCLES      = SHORT_TO + 8 * OS_CYCLES;
  localparam int WATCHDOG_CYCLES = 2 * (10 + 3 * TRAIN_CYCLES + WIDTH_CYCLES + TS2_CYCLES + 100);

  // ordered-set classes in training order
  localparam int C_PAD  = 0;
  localparam int C_LANE = 1;
  localparam int C_TS2  = 2;
  localparam int C_IDLE = 3;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 en;
  logic [NUM_LANES-1:0] width_sat;
  logic                 lanes_formed;
  logic                 nums_match;
  logic                 reconfig;
  logic [NUM_LANES-1:0] complete_ts2;
  logic                 single_idle;
  logic                 idle_sat;
  logic                 tready;
  beat_t                tdata;
  stream_user_t         tuser;
  logic                 tvalid;
  logic                 tlast;
  logic                 success;
  logic                 error;
  logic                 bp_on;
  logic [31:0]          lfsr = 32'hf750_15cf;
  int                   n_checks = 0;
  int                   n_errors = 0;
  int                   os_count = 0;
  logic [1:0]           os_log [512];

  ltssm_config #(
    .NUM_LANES     (NUM_LANES),
    .LINK_NUM      (LINK_NUM),
    .LONG_TIMEOUT  (LONG_TO),
    .SHORT_TIMEOUT (SHORT_TO)
  ) u_ltssm_config (
    .clk_i                   (clk),
    .rst_i                   (rst),
    .en_i                    (en),
    .link_width_satisfied_i  (width_sat),
    .link_lanes_formed_i     (lanes_formed),
    .link_lanes_nums_match_i (nums_match),
    .link_lane_reconfig_i    (reconfig),
    .config_complete_ts2_i   (complete_ts2),
    .single_idle_rx_i        (single_idle),
    .link_idle_satisfied_i   (idle_sat),
    .os_tdata_o              (tdata),
    .os_tuser_o              (tuser),
    .os_tvalid_o             (tvalid),
    .os_tlast_o              (tlast),
    .os_tready_i             (tready),
    .success_o               (success),
    .error_o                 (error)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  always @(posedge clk) begin
    if (bp_on) begin
      lfsr = lfsr_step(lfsr);
      tready <= lfsr[0];
    end else begin
      tready <= 1'b1;
    end
  end

  // 16 symbols, symbol 0 in the low byte
  function automatic logic [127:0] expected_os(input int cls);
    symbol_t      sym;
    logic [127:0] os;
    os = '0;
    for (int i = 0; i < 16; i++) begin
      if (cls == C_IDLE) begin
        sym = SYM_IDLE;
      end else begin
        case (i)
          0: sym = SYM_COM;
          1: sym = symbol_t'(LINK_NUM);
          2: sym = (cls == C_PAD) ? SYM_PAD : 8'h00;
          3: sym = NFTS_VALUE;
          4: sym = RATE_GEN1;
          5: sym = 8'h00;
          default: sym = (cls == C_TS2) ? SYM_TS2_ID : SYM_TS1_ID;
        endcase
      end
      os[8*i +: 8] = sym;
    end
    return os;
  endfunction

  function automatic int os_class(input logic [127:0] os);
    if (os[7:0] == SYM_IDLE) return C_IDLE;
    if (os[23:16] == SYM_PAD) return C_PAD;
    if (os[55:48] == SYM_TS2_ID) return C_TS2;
    return C_LANE;
  endfunction

  task automatic check_os(input logic [127:0] got, input logic [31:0] users, input int cls);
    logic [127:0] exp;
    stream_user_t exp_user;
    exp = expected_os(cls);
    exp_user = (cls == C_PAD) ? USER_FIRST_TS1 : USER_LANE_OS;
    n_checks++;
    if (got !== exp) begin
      $display("ERR os_tdata_o set %0d: got %h expected %h", os_count, got, exp);
      n_errors++;
    end
    if (users !== {4{exp_user}}) begin
      $display("ERR os_tuser_o set %0d: got %h expected %h", os_count, users, {4{exp_user}});
      n_errors++;
    end
  endtask

  // collects beats into ordered sets and checks stalls
  always @(posedge clk) begin : monitor
    logic [127:0] os_data;
    logic [31:0]  os_user;
    int           beat_idx;
    int           cls;
    logic         stall_q;
    beat_t        tdata_q;
    stream_user_t tuser_q;
    if (rst) begin
      beat_idx = 0;
      stall_q <= 1'b0;
    end else begin
      if (stall_q) begin
        n_checks++;
        if (!tvalid) begin
          $display("os_tvalid_o dropped while a beat was stalled");
          n_errors++;
        end
        if (tdata !== tdata_q) begin
          $display("ERR os_tdata_o stalled beat: got %h expected %h", tdata, tdata_q);
          n_errors++;
        end
        if (tuser !== tuser_q) begin
          $display("ERR os_tuser_o stalled beat: got %h expected %h", tuser, tuser_q);
          n_errors++;
        end
      end
      if (tvalid && tready) begin
        if (tlast !== (beat_idx == BEATS_PER_OS - 1)) begin
          $display("ERR os_tlast_o beat %0d: got %h expected %h", beat_idx, tlast,
                   beat_idx == BEATS_PER_OS - 1);
          n_errors++;
        end
        os_data[32*beat_idx +: 32] = tdata;
        os_user[8*beat_idx +: 8] = tuser;
        if (beat_idx == BEATS_PER_OS - 1) begin
          cls = os_class(os_data);
          check_os(os_data, os_user, cls);
          os_log[os_count] <= 2'(cls);
          os_count <= os_count + 1;
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
      stall_q <= tvalid && !tready;
      tdata_q <= tdata;
      tuser_q <= tuser;
    end
  end

  task automatic expect_level(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic wait_os_count(input int n, input int limit);
    int waited;
    waited = 0;
    while (os_count < n && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (os_count < n) begin
      $display("timed out waiting for ordered set %0d", n);
      n_errors++;
    end
  endtask

  task automatic wait_class(input int cls, input int base, input int limit);
    int waited;
    waited = 0;
    while (!(os_count > base && os_log[os_count-1] == cls) && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (waited >= limit) begin
      $display("timed out waiting for an ordered set of class %0d", cls);
      n_errors++;
    end
  endtask

  task automatic wait_result(input int limit);
    int waited;
    waited = 0;
    while (!success && !error && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (!success && !error) begin
      $display("neither success nor error within %0d cycles", limit);
      n_errors++;
    end
  endtask

  task automatic check_sequence(input int base, input int lane_n, input int ts2_min,
                                input int ts2_max, input int idle_n);
    int cnt [4];
    int prev;
    cnt = '{0, 0, 0, 0};
    prev = C_PAD;
    n_checks++;
    for (int i = base; i < os_count; i++) begin
      if (int'(os_log[i]) < prev) begin
        $display("ordered set %0d is out of training order", i);
        n_errors++;
      end
      prev = os_log[i];
      cnt[os_log[i]]++;
    end
    if (cnt[C_PAD] < 1 || cnt[C_LANE] != lane_n || cnt[C_TS2] < ts2_min ||
        cnt[C_TS2] > ts2_max || cnt[C_IDLE] != idle_n) begin
      $display("wrong ordered set counts: pad TS1 %0d, lane TS1 %0d, TS2 %0d, IDLE %0d",
               cnt[C_PAD], cnt[C_LANE], cnt[C_TS2], cnt[C_IDLE]);
      n_errors++;
    end
  endtask

  // drop en and every status, result flags must clear
  task automatic release_link();
    int waited;
    waited = 0;
    en <= 1'b0;
    width_sat <= '0;
    lanes_formed <= 1'b0;
    nums_match <= 1'b0;
    reconfig <= 1'b0;
    complete_ts2 <= '0;
    single_idle <= 1'b0;
    idle_sat <= 1'b0;
    while ((success || error) && waited < 8) begin
      @(posedge clk);
      waited++;
    end
    if (success || error) begin
      $display("success or error still high after en dropped");
      n_errors++;
    end
    @(posedge clk);
  endtask

  task automatic full_training();
    int base;
    base = os_count;
    single_idle <= 1'b1;
    idle_sat <= 1'b1;
    en <= 1'b1;
    wait_os_count(base + 2, TRAIN_CYCLES);
    width_sat <= 4'b0100;
    lanes_formed <= 1'b1;
    wait_class(C_LANE, base, TRAIN_CYCLES);
    complete_ts2 <= '1;
    nums_match <= 1'b1;
    wait_result(TRAIN_CYCLES);
    expect_level("success_o", success, 1'b1);
    expect_level("error_o", error, 1'b0);
    check_sequence(base, 1, 1, 1, 17);
    release_link();
  endtask

  task automatic width_timeout();
    int base;
    base = os_count;
    en <= 1'b1;
    wait_result(WIDTH_CYCLES);
    expect_level("error_o", error, 1'b1);
    expect_level("success_o", success, 1'b0);
    check_sequence(base, 0, 0, 0, 0);
    release_link();
  endtask

  task automatic backpressure_training();
    bp_on <= 1'b1;
    full_training();
    bp_on <= 1'b0;
  endtask

  task automatic lane_reconfig();
    int base;
    int n;
    base = os_count;
    width_sat <= '1;
    lanes_formed <= 1'b1;
    complete_ts2 <= '1;
    single_idle <= 1'b1;
    idle_sat <= 1'b1;
    en <= 1'b1;
    wait_class(C_LANE, base, TRAIN_CYCLES);
    repeat (4) @(posedge clk);
    n = os_count;
    reconfig <= 1'b1;
    @(posedge clk);
    reconfig <= 1'b0;
    wait_os_count(n + 1, TRAIN_CYCLES);
    repeat (8) @(posedge clk);
    nums_match <= 1'b1;
    wait_result(TRAIN_CYCLES);
    expect_level("success_o", success, 1'b1);
    expect_level("error_o", error, 1'b0);
    check_sequence(base, 2, 1, 1, 17);
    release_link();
  endtask

  task automatic ts2_timeout();
    int base;
    base = os_count;
    width_sat <= '1;
    lanes_formed <= 1'b1;
    nums_match <= 1'b1;
    // lane 1 never completes
    complete_ts2 <= 4'b1101;
    en <= 1'b1;
    wait_result(TS2_CYCLES);
    expect_level("error_o", error, 1'b1);
    expect_level("success_o", success, 1'b0);
    check_sequence(base, 1, 2, 1000, 0);
    release_link();
  endtask

  initial begin
    rst <= 1'b1;
    en <= 1'b0;
    width_sat <= '0;
    lanes_formed <= 1'b0;
    nums_match <= 1'b0;
    reconfig <= 1'b0;
    complete_ts2 <= '0;
    single_idle <= 1'b0;
    idle_sat <= 1'b0;
    tready <= 1'b1;
    bp_on <= 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    full_training();
    width_timeout();
    backpressure_training();
    lane_reconfig();
    ts2_timeout();
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
